// File: dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	localparam int ADDR_W   = 32;
	localparam int ID_W     = 8;
	localparam int OFFSET_W = 6;  // 64-byte lines
	localparam int INDEX_W  = 10;
	localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

	// processor read/write address request
	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;
	} axi_req_t;

	// metadata read towards the memory controller
	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] meta_addr;
	} meta_req_t;

	typedef struct packed {
		logic             line_valid;
		logic [TAG_W-1:0] tag;
	} meta_rsp_t;

	// one pending lookup parked until its metadata returns
	typedef struct packed {
		logic              is_write;
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
	} pend_req_t;

	typedef struct packed {
		logic              is_write;
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic              hit;
	} lookup_result_t;

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		RECOVER
	} ext_state_e;

endpackage

`default_nettype wire

// File: index_extractor.sv
`default_nettype none

module index_extractor
	import dcache_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,

	// processor read channel
	input  wire axi_req_t ar_req_i,
	input  wire        ar_valid_i,
	output logic       ar_ready_o,

	// processor write channel
	input  wire axi_req_t aw_req_i,
	input  wire        aw_valid_i,
	output logic       aw_ready_o,

	// pending FIFO
	input  wire        fifo_afull_i,
	output logic       fifo_wr_o,
	output pend_req_t  fifo_entry_o,

	// metadata read to the memory controller
	output meta_req_t  meta_req_o,
	output logic       meta_valid_o,
	input  wire        meta_ready_i
);

	ext_state_e state;
	logic       wr_pref;    // set when the write channel wins a tie
	pend_req_t  entry;      // request being looked up
	logic       open_win;
	logic       ar_acc;
	logic       aw_acc;
	logic       meta_xfer;
	logic [ADDR_W-1:0] meta_addr;

	// accept window is idle with room left for one more entry
	assign open_win = (state == IDLE) && !fifo_afull_i;

	// a lone valid always gets through and a tie goes to the preferred side
	assign ar_ready_o = open_win && (!aw_valid_i || !wr_pref);
	assign aw_ready_o = open_win && (!ar_valid_i || wr_pref);

	assign ar_acc = ar_valid_i && ar_ready_o;
	assign aw_acc = aw_valid_i && aw_ready_o;

	assign meta_xfer = (state == ISSUE) && meta_ready_i;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= IDLE;
			wr_pref <= 1'b0;  // reads first after reset
		end else begin
			case (state)
				IDLE: begin
					if (ar_acc || aw_acc) begin
						state   <= ISSUE;
						wr_pref <= ar_acc;  // other side next time
					end
				end
				ISSUE: begin
					if (meta_ready_i) begin
						state <= RECOVER;
					end
				end
				RECOVER: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// capture the accepted request
	always_ff @(posedge clk) begin
		if (ar_acc) begin
			entry.is_write <= 1'b0;
			entry.id       <= ar_req_i.id;
			entry.addr     <= ar_req_i.addr;
		end else if (aw_acc) begin
			entry.is_write <= 1'b1;
			entry.id       <= aw_req_i.id;
			entry.addr     <= aw_req_i.addr;
		end
	end

	// metadata lives at the set index with tag and offset cleared
	assign meta_addr = {
		{TAG_W{1'b0}},
		entry.addr[OFFSET_W +: INDEX_W],
		{OFFSET_W{1'b0}}
	};

	assign meta_req_o   = '{id: entry.id, meta_addr: meta_addr};
	assign meta_valid_o = (state == ISSUE);

	// park the request on the same edge the metadata read goes out
	assign fifo_wr_o    = meta_xfer;
	assign fifo_entry_o = entry;

endmodule

`default_nettype wire

// File: req_fifo.sv
`default_nettype none

module req_fifo
	import dcache_pkg::*;
#(
	parameter int FIFO_DEPTH = 4  // power of two of 2 or more
)
(
	input  wire        clk,
	input  wire        rst_n,
	input  wire        wr_i,
	input  wire pend_req_t wr_entry_i,
	input  wire        rd_i,
	output pend_req_t  head_o,
	output logic       afull_o
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam logic [PTR_W:0] FULL_LVL  = (PTR_W + 1)'(FIFO_DEPTH);
	localparam logic [PTR_W:0] AFULL_LVL = (PTR_W + 1)'(FIFO_DEPTH - 1);

	pend_req_t        mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_wr;
	logic             do_rd;

	assign do_wr = wr_i && (count != FULL_LVL);
	assign do_rd = rd_i && (count != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;  // wraps since depth is a power of two
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_entry_i;
	end

	assign head_o = mem[rd_ptr];

	// raised one slot early so an in-flight request still fits
	assign afull_o = (count >= AFULL_LVL);

endmodule

`default_nettype wire

// File: hit_checker.sv
`default_nettype none

module hit_checker
	import dcache_pkg::*;
(
	input  wire            clk,
	input  wire            rst_n,

	// oldest pending request
	input  wire pend_req_t head_i,
	output logic           pop_o,

	// in-order metadata from the memory controller
	input  wire meta_rsp_t meta_rsp_i,
	input  wire            meta_rsp_valid_i,

	output lookup_result_t result_o,
	output logic           result_valid_o
);

	logic [TAG_W-1:0] head_tag;
	logic             hit;

	// tag is the top of the request address
	assign head_tag = head_i.addr[ADDR_W-1 -: TAG_W];

	// an invalid line never hits whatever its stored tag
	assign hit = meta_rsp_i.line_valid && (meta_rsp_i.tag == head_tag);

	// responses come back in issue order so each one belongs to the head
	assign pop_o = meta_rsp_valid_i;

	always_ff @(posedge clk) begin
		if (!rst_n)
			result_valid_o <= 1'b0;
		else
			result_valid_o <= meta_rsp_valid_i;  // one-cycle pulse
	end

	always_ff @(posedge clk) begin
		if (meta_rsp_valid_i) begin
			result_o <= '{
				is_write: head_i.is_write,
				id:       head_i.id,
				addr:     head_i.addr,
				hit:      hit
			};
		end
	end

endmodule

`default_nettype wire

// File: dcache_front.sv
`default_nettype none

module dcache_front
	import dcache_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
)
(
	input  wire            clk,
	input  wire            rst_n,

	input  wire axi_req_t  ar_req_i,
	input  wire            ar_valid_i,
	output logic           ar_ready_o,
	input  wire axi_req_t  aw_req_i,
	input  wire            aw_valid_i,
	output logic           aw_ready_o,

	output meta_req_t      meta_req_o,
	output logic           meta_valid_o,
	input  wire            meta_ready_i,
	input  wire meta_rsp_t meta_rsp_i,
	input  wire            meta_rsp_valid_i,

	output lookup_result_t result_o,
	output logic           result_valid_o
);

	logic      fifo_wr;
	pend_req_t fifo_entry;
	logic      fifo_afull;
	logic      fifo_pop;
	pend_req_t fifo_head;

	index_extractor u_extractor (
		.clk          (clk),
		.rst_n        (rst_n),
		.ar_req_i     (ar_req_i),
		.ar_valid_i   (ar_valid_i),
		.ar_ready_o   (ar_ready_o),
		.aw_req_i     (aw_req_i),
		.aw_valid_i   (aw_valid_i),
		.aw_ready_o   (aw_ready_o),
		.fifo_afull_i (fifo_afull),
		.fifo_wr_o    (fifo_wr),
		.fifo_entry_o (fifo_entry),
		.meta_req_o   (meta_req_o),
		.meta_valid_o (meta_valid_o),
		.meta_ready_i (meta_ready_i)
	);

	// requests waiting for their metadata
	req_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_pend_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_i       (fifo_wr),
		.wr_entry_i (fifo_entry),
		.rd_i       (fifo_pop),
		.head_o     (fifo_head),
		.afull_o    (fifo_afull)
	);

	hit_checker u_hit_checker (
		.clk              (clk),
		.rst_n            (rst_n),
		.head_i           (fifo_head),
		.pop_o            (fifo_pop),
		.meta_rsp_i       (meta_rsp_i),
		.meta_rsp_valid_i (meta_rsp_valid_i),
		.result_o         (result_o),
		.result_valid_o   (result_valid_o)
	);

endmodule

`default_nettype wire

// File: dcache_checker.sv
`default_nettype none

module dcache_checker
	import dcache_pkg::*;
(
	input  wire            clk,
	input  wire            rst_n,
	input  wire axi_req_t  ar_req_i,
	input  wire            ar_valid_i,
	input  wire            ar_ready_i,
	input  wire axi_req_t  aw_req_i,
	input  wire            aw_valid_i,
	input  wire            aw_ready_i,
	input  wire meta_req_t meta_req_i,
	input  wire            meta_valid_i,
	input  wire            meta_ready_i,
	input  wire meta_rsp_t meta_rsp_i,
	input  wire            meta_rsp_valid_i,
	input  wire lookup_result_t result_i,
	input  wire            result_valid_i,
	input  wire            alt_check_i,  // results must alternate between read and write
	input  wire            report_i,
	input  int             tb_errors_i,
	output int             err_count_o,
	output int             pending_o
);

	localparam logic [ADDR_W-1:0] INDEX_MASK =
		ADDR_W'(((1 << INDEX_W) - 1) << OFFSET_W);

	pend_req_t      exp_q[$];  // accepted and waiting for a result
	meta_rsp_t      rsp_q[$];
	pend_req_t      req;
	lookup_result_t exp;
	int             issued;    // entries of exp_q whose meta read went out
	int             errors;
	int             end_errors;
	int             results;
	logic           next_write;

	assign err_count_o = errors + end_errors;
	assign pending_o   = exp_q.size();

	// expected lookup hits only on a valid line whose tag matches the address top bits
	function automatic lookup_result_t expect_result(pend_req_t r, meta_rsp_t m);
		lookup_result_t e;
		e.is_write = r.is_write;
		e.id       = r.id;
		e.addr     = r.addr;
		e.hit      = m.line_valid && (m.tag == r.addr[ADDR_W-1 -: TAG_W]);
		return e;
	endfunction

	always @(posedge clk) begin
		if (!rst_n) begin
			exp_q.delete();
			rsp_q.delete();
			issued     = 0;
			next_write = 1'b0;
		end else begin
			if (result_valid_i) begin
				if (exp_q.size() == 0 || rsp_q.size() == 0) begin
					$display("%0t: result came out with no pending request", $time);
					errors++;
				end else begin
					exp = expect_result(exp_q.pop_front(), rsp_q.pop_front());
					issued--;
					results++;
					if (result_i !== exp) begin
						$display("CHECK FAILED at %0t: result %h, expected %h", $time,
							result_i, exp);
						errors++;
					end
					if (alt_check_i) begin
						if (result_i.is_write !== next_write) begin
							$display("CHECK FAILED at %0t: is_write %b out of turn", $time,
								result_i.is_write);
							errors++;
						end
						next_write = !next_write;
					end
				end
			end
			if (meta_rsp_valid_i)
				rsp_q.push_back(meta_rsp_i);
			if (meta_valid_i && meta_ready_i) begin
				if (issued >= exp_q.size()) begin
					$display("%0t: meta read issued with no accepted request", $time);
					errors++;
				end else begin
					req = exp_q[issued];
					issued++;
					if (meta_req_i.id !== req.id ||
						meta_req_i.meta_addr !== (req.addr & INDEX_MASK)) begin
						$display("CHECK FAILED at %0t: meta read %h, request %h", $time,
							meta_req_i, req);
						errors++;
					end
				end
			end
			if (ar_valid_i && ar_ready_i)
				exp_q.push_back({1'b0, ar_req_i.id, ar_req_i.addr});
			if (aw_valid_i && aw_ready_i)
				exp_q.push_back({1'b1, aw_req_i.id, aw_req_i.addr});
		end
	end

	always @(posedge report_i) begin
		if (exp_q.size() != 0) begin
			$display("%0d accepted requests never produced a result", exp_q.size());
			end_errors++;
		end
		$display("summary: %0d results, %0d checker errors, %0d testbench errors",
			results, errors + end_errors, tb_errors_i);
	end

endmodule

`default_nettype wire

// File: tb_dcache_front.sv
`default_nettype none

module tb_dcache_front;
	import dcache_pkg::*;

	localparam int FIFO_DEPTH = 4;
	localparam int TIMEOUT    = 500;

	logic           clk = 1'b0;
	logic           rst_n;
	axi_req_t       ar_req;
	logic           ar_valid;
	logic           ar_ready;
	axi_req_t       aw_req;
	logic           aw_valid;
	logic           aw_ready;
	meta_req_t      meta_req;
	logic           meta_valid;
	logic           meta_ready;
	meta_rsp_t      meta_rsp;
	logic           meta_rsp_valid;
	lookup_result_t result;
	logic           result_valid;
	logic           alt_check;
	logic           report;
	int             tb_errors;
	int             chk_errors;
	int             chk_pending;
	int             accepted;
	logic [ID_W-1:0] next_id;

	// memory controller model
	logic             tag_valid [1 << INDEX_W];
	logic [TAG_W-1:0] tag_val [1 << INDEX_W];
	logic [INDEX_W-1:0] idx_q[$];  // issued meta reads answered in order
	logic [INDEX_W-1:0] rsp_idx;
	int               rsp_wait;
	logic             rsp_hold;
	logic             rand_timing;

	always #5 clk = ~clk;

	dcache_front #(.FIFO_DEPTH(FIFO_DEPTH)) uut (
		.clk(clk), .rst_n(rst_n),
		.ar_req_i(ar_req), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
		.aw_req_i(aw_req), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
		.meta_req_o(meta_req), .meta_valid_o(meta_valid), .meta_ready_i(meta_ready),
		.meta_rsp_i(meta_rsp), .meta_rsp_valid_i(meta_rsp_valid),
		.result_o(result), .result_valid_o(result_valid)
	);

	dcache_checker chk (
		.clk(clk), .rst_n(rst_n),
		.ar_req_i(ar_req), .ar_valid_i(ar_valid), .ar_ready_i(ar_ready),
		.aw_req_i(aw_req), .aw_valid_i(aw_valid), .aw_ready_i(aw_ready),
		.meta_req_i(meta_req), .meta_valid_i(meta_valid), .meta_ready_i(meta_ready),
		.meta_rsp_i(meta_rsp), .meta_rsp_valid_i(meta_rsp_valid),
		.result_i(result), .result_valid_i(result_valid),
		.alt_check_i(alt_check), .report_i(report), .tb_errors_i(tb_errors),
		.err_count_o(chk_errors), .pending_o(chk_pending)
	);

	always @(posedge clk) begin
		if (!rst_n)
			idx_q.delete();
		else if (meta_valid && meta_ready)
			idx_q.push_back(meta_req.meta_addr[OFFSET_W +: INDEX_W]);
	end

	always @(negedge clk) begin
		meta_ready     = rand_timing ? (($urandom % 3) != 0) : 1'b1;
		meta_rsp_valid = 1'b0;
		if (!rsp_hold && idx_q.size() > 0) begin
			if (rsp_wait > 0) begin
				rsp_wait--;
			end else begin
				rsp_idx        = idx_q.pop_front();
				meta_rsp       = {tag_valid[rsp_idx], tag_val[rsp_idx]};
				meta_rsp_valid = 1'b1;
				rsp_wait       = rand_timing ? ($urandom % 4) : 0;
			end
		end
	end

	function automatic axi_req_t rand_req();
		axi_req_t r;
		r.id    = next_id;
		r.addr  = $urandom;
		r.len   = 8'd0;
		next_id = next_id + 1'b1;
		return r;
	endfunction

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic send_req(input logic is_write, input logic [ADDR_W-1:0] addr);
		int t;
		logic took;
		axi_req_t r;
		r      = rand_req();
		r.addr = addr;
		t      = 0;
		took   = 1'b0;
		if (is_write) begin
			aw_req   = r;
			aw_valid = 1'b1;
		end else begin
			ar_req   = r;
			ar_valid = 1'b1;
		end
		do begin
			@(posedge clk);
			took = is_write ? aw_ready : ar_ready;
			t++;
		end while (!took && t < TIMEOUT);
		if (!took) begin
			$display("%0t: request was never accepted", $time);
			tb_errors++;
		end
		@(negedge clk);
		ar_valid = 1'b0;
		aw_valid = 1'b0;
	endtask

	// both channels valid every cycle with a new request as soon as one is taken
	task automatic drive_both(input int cycles);
		logic ar_took;
		logic aw_took;
		ar_req   = rand_req();
		aw_req   = rand_req();
		ar_valid = 1'b1;
		aw_valid = 1'b1;
		repeat (cycles) begin
			@(posedge clk);
			ar_took = ar_ready;
			aw_took = aw_ready;
			@(negedge clk);
			if (ar_took) begin
				ar_req = rand_req();
				accepted++;
			end
			if (aw_took) begin
				aw_req = rand_req();
				accepted++;
			end
		end
		ar_valid = 1'b0;
		aw_valid = 1'b0;
	endtask

	task automatic drain();
		int t;
		t = 0;
		while ((chk_pending != 0 || idx_q.size() != 0) && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (chk_pending != 0 || idx_q.size() != 0) begin
			$display("%0t: pending requests did not drain", $time);
			tb_errors++;
		end
		repeat (3) @(negedge clk);
	endtask

	initial begin
		void'($urandom(32'h77eaf632));
		rst_n = 1'b0;
		ar_req = '0;
		ar_valid = 1'b0;
		aw_req = '0;
		aw_valid = 1'b0;
		meta_ready = 1'b0;
		meta_rsp = '0;
		meta_rsp_valid = 1'b0;
		alt_check = 1'b0;
		report = 1'b0;
		tb_errors = 0;
		accepted = 0;
		next_id = '0;
		rsp_wait = 0;
		rsp_hold = 1'b0;
		rand_timing = 1'b0;
		for (int i = 0; i < (1 << INDEX_W); i++) begin
			tag_valid[i] = 1'($urandom);
			tag_val[i]   = TAG_W'($urandom);
		end
		apply_reset();

		@(negedge clk);
		ar_req   = rand_req();
		ar_valid = 1'b1;
		#1;
		if (meta_valid !== 1'b0 || result_valid !== 1'b0 || ar_ready !== 1'b1) begin
			$display("CHECK FAILED at %0t: bad meta_valid, result_valid or ar_ready after reset",
				$time);
			tb_errors++;
		end
		@(negedge clk);
		ar_valid = 1'b0;

		// hit, tag mismatch and invalid line for reads then writes
		for (int k = 0; k < 6; k++) begin
			logic [ADDR_W-1:0] a;
			a = {TAG_W'($urandom), INDEX_W'(k + 16), OFFSET_W'($urandom)};
			tag_valid[k + 16] = (k % 3) != 2;
			tag_val[k + 16]   = (k % 3 == 1) ? ~a[ADDR_W-1 -: TAG_W] : a[ADDR_W-1 -: TAG_W];
			send_req(k >= 3, a);
		end
		drain();

		apply_reset();
		alt_check = 1'b1;
		drive_both(30);
		drain();
		alt_check = 1'b0;

		rsp_hold = 1'b1;
		accepted = 0;
		drive_both(40);
		if (accepted != FIFO_DEPTH - 1 || ar_ready || aw_ready) begin
			$display("CHECK FAILED at %0t: %0d requests taken with responses stalled",
				$time, accepted);
			tb_errors++;
		end
		rsp_hold = 1'b0;
		drain();

		rand_timing = 1'b1;
		repeat (40)
			send_req(1'($urandom), $urandom);
		drain();

		report = 1'b1;
		#1;
		if (chk_errors == 0 && tb_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
dcache_pkg.sv
index_extractor.sv
req_fifo.sv
hit_checker.sv
dcache_front.sv
dcache_checker.sv
tb_dcache_front.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the dcache front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_dcache_front -f build.f \
	--Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	exit 1
fi
exit 0
